// File: files.f
+incdir+src
src/i2c_pkg.sv
src/i2c_bit_ctrl.sv
src/i2c_master.sv
src/eeprom_slave.sv
src/eeprom_subsystem.sv
sim/tb_eeprom_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_eeprom_subsystem
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= FAIL: see errors above
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_eeprom_subsystem.sv
`include "i2c_defs.svh"

module tb_eeprom_subsystem
    import i2c_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_RAND = 20;
    // Control, address and data bytes of every transfer in the run.
    localparam int XFER_BYTES = 3 * 7 + 13 + 2 + 7 + N_RAND * 7;
    localparam int WATCHDOG_NS = XFER_BYTES * 9 * 4 * `I2C_CLK_DIV * 10 * 2;

    typedef logic [7:0] byte_q_t [$];

    logic       sda;
    logic       reset;
    logic       cyc;
    logic       stb;
    logic       we;
    logic [1:0] adr;
    logic [7:0] dat_w;
    logic [7:0] dat_r;
    logic       ack;

    logic [7:0] ref_mem [0:`EE_MEM_SIZE-1];   // Expected EEPROM contents.
    int         errors;
    int         checks;
    integer     seed;

    eeprom_subsystem i_dut (
        .sda   (sda),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .dat_r (dat_r),
        .ack   (ack)
    );

    always #5 sda = ~sda;

    task automatic check(input string name, input logic [7:0] actual,
                         input logic [7:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("ERR %s: got 0x%02h, expected 0x%02h", name, actual, expected);
        end
    endtask

    task automatic wb_write(input logic [1:0] a, input logic [7:0] d);
        @(posedge sda);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= 1'b1;
        adr   <= a;
        dat_w <= d;
        @(posedge sda);
        while (!ack)
            @(posedge sda);
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [1:0] a, output logic [7:0] d);
        @(posedge sda);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b0;
        adr <= a;
        @(posedge sda);
        while (!ack)
            @(posedge sda);
        d = dat_r;
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    // One byte out, then STATUS must show the expected ninth bit.
    task automatic send_byte(input logic [7:0] b, input logic start, input logic stop,
                             input logic nack_exp);
        cmd_reg_t    cmd;
        status_reg_t exp_st;
        logic [7:0]  st;
        cmd         = '0;
        cmd.start   = start;
        cmd.stop    = stop;
        cmd.write   = 1'b1;
        exp_st.busy    = 1'b0;
        exp_st.rx_nack = nack_exp;
        wb_write(`REG_DATA, b);
        wb_write(`REG_CMD, {3'b000, cmd});
        wb_read(`REG_STATUS, st);
        check("STATUS", st, {6'b0, exp_st});
    endtask

    task automatic recv_byte(input logic nack, input logic stop, output logic [7:0] b);
        cmd_reg_t cmd;
        cmd      = '0;
        cmd.read = 1'b1;
        cmd.nack = nack;
        cmd.stop = stop;
        wb_write(`REG_CMD, {3'b000, cmd});
        wb_read(`REG_DATA, b);
    endtask

    task automatic ee_write_bytes(input logic [`EE_ADDR_W-1:0] addr, input byte_q_t data);
        logic [`EE_ADDR_W-1:0] a;
        send_byte({`EE_DEVICE_CODE, addr[`EE_ADDR_W-1:8], 1'b0}, 1'b1, 1'b0, 1'b0);
        send_byte(addr[7:0], 1'b0, 1'b0, 1'b0);
        a = addr;
        foreach (data[i])
        begin
            send_byte(data[i], 1'b0, i == data.size() - 1, 1'b0);
            ref_mem[a] = data[i];
            a = a + 1'b1;    // 11-bit counter wraps at 2047.
        end
    endtask

    // Random read when set_addr is high, current-address read otherwise.
    task automatic ee_read_bytes(input logic [`EE_ADDR_W-1:0] addr, input int n,
                                 input logic set_addr);
        logic [`EE_ADDR_W-1:0] a;
        logic [7:0]            b;
        if (set_addr)
        begin
            send_byte({`EE_DEVICE_CODE, addr[`EE_ADDR_W-1:8], 1'b0}, 1'b1, 1'b0, 1'b0);
            send_byte(addr[7:0], 1'b0, 1'b0, 1'b0);
        end
        send_byte({`EE_DEVICE_CODE, addr[`EE_ADDR_W-1:8], 1'b1}, 1'b1, 1'b0, 1'b0);
        a = addr;
        for (int i = 0; i < n; i++)
        begin
            recv_byte(i == n - 1, i == n - 1, b);   // Last byte gets nack and stop.
            check($sformatf("mem[0x%03h]", a), b, ref_mem[a]);
            a = a + 1'b1;
        end
    endtask

    task automatic reset_values();
        logic [7:0] v;
        wb_read(`REG_STATUS, v);
        check("STATUS", v, 8'h00);
        wb_write(`REG_DATA, 8'h5C);
        wb_read(`REG_DATA, v);
        check("DATA", v, 8'h5C);
    endtask

    task automatic single_write_read();
        byte_q_t q;
        q = {8'h96};
        ee_write_bytes(11'h5A3, q);     // Block 5 from the control byte.
        q = {8'h69};
        ee_write_bytes(11'h0A3, q);     // Same address byte in block 0.
        ee_read_bytes(11'h5A3, 1, 1'b1);
        ee_read_bytes(11'h0A3, 1, 1'b1);
        q = {8'h4B};
        ee_write_bytes(11'h002, q);
        ee_read_bytes(11'h002, 1, 1'b1);
    endtask

    task automatic sequential_wrap();
        byte_q_t q;
        q = {8'hC3, 8'h3C, 8'hA5, 8'h5A};
        ee_write_bytes(11'h7FE, q);
        ee_read_bytes(11'h7FE, 4, 1'b1);
    endtask

    // Four bytes from 0x7FE leave the counter at 0x002.
    task automatic current_address_read();
        ee_read_bytes(11'h002, 1, 1'b0);
    endtask

    task automatic wrong_device_code();
        logic [7:0] bad_ctrl;
        bad_ctrl = {`EE_DEVICE_CODE ^ 4'b0001, 3'd5, 1'b0};
        send_byte(bad_ctrl, 1'b1, 1'b0, 1'b1);
        send_byte(8'hA3, 1'b0, 1'b0, 1'b1);
        send_byte(~ref_mem[11'h5A3], 1'b0, 1'b1, 1'b1);
        ee_read_bytes(11'h5A3, 1, 1'b1);
    endtask

    task automatic random_writes();
        logic [`EE_ADDR_W-1:0] addrs [N_RAND];
        logic [31:0]           r;
        byte_q_t               q;
        for (int i = 0; i < N_RAND; i++)
        begin
            r = $random(seed);
            addrs[i] = r[`EE_ADDR_W-1:0];
            r = $random(seed);
            q = {r[7:0]};
            ee_write_bytes(addrs[i], q);
        end
        for (int i = 0; i < N_RAND; i++)
            ee_read_bytes(addrs[i], 1, 1'b1);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests were still running after %0d ns", WATCHDOG_NS);
        $display("%0d checks, %0d errors", checks, errors);
        $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        seed   = 92;
        errors = 0;
        checks = 0;
        sda    = 1'b0;
        reset  = 1'b1;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = 2'd0;
        dat_w  = 8'h00;
        repeat (2) @(posedge sda);
        reset <= 1'b0;

        reset_values();
        single_write_read();
        sequential_wrap();
        current_address_read();
        wrong_device_code();
        random_writes();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: src/eeprom_subsystem.sv
module eeprom_subsystem
    import i2c_pkg::*;
(
    input  logic       sda,
    input  logic       reset,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  logic [7:0] dat_w,
    output logic [7:0] dat_r,
    output logic       ack
);
    i2c_bus_t   bus;
    i2c_drive_t master_drive;
    i2c_drive_t eeprom_drive;

    // A line is high unless some agent pulls it low.
    assign bus.scl  = !(master_drive.scl_low || eeprom_drive.scl_low);
    assign bus.data = !(master_drive.data_low || eeprom_drive.data_low);

    i2c_master i_master (
        .sda   (sda),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .bus   (bus),
        .dat_r (dat_r),
        .ack   (ack),
        .drive (master_drive)
    );

    eeprom_slave i_eeprom (
        .sda   (sda),
        .reset (reset),
        .bus   (bus),
        .drive (eeprom_drive)
    );

endmodule

// File: src/eeprom_slave.sv
`include "i2c_defs.svh"

module eeprom_slave
    import i2c_pkg::*;
(
    input  logic       sda,
    input  logic       reset,
    input  i2c_bus_t   bus,
    output i2c_drive_t drive
);
    logic [7:0]            mem [0:`EE_MEM_SIZE-1];
    slave_state_e          state;
    slave_state_e          ack_next;   // Where to go after the acknowledge.
    i2c_bus_t              bus_q;
    logic [7:0]            shift;
    logic [2:0]            bit_cnt;
    logic [`EE_ADDR_W-1:0] addr;
    logic                  data_low;
    logic                  start_det;
    logic                  stop_det;
    logic                  scl_rise;
    logic                  scl_fall;
    logic [7:0]            byte_in;
    logic [7:0]            rd_byte;
    logic                  mem_we;

    assign start_det = bus_q.scl && bus.scl && bus_q.data && !bus.data;
    assign stop_det  = bus_q.scl && bus.scl && !bus_q.data && bus.data;
    assign scl_rise  = !bus_q.scl && bus.scl;
    assign scl_fall  = bus_q.scl && !bus.scl;
    assign byte_in   = {shift[6:0], bus.data};
    assign rd_byte   = mem[addr];
    assign mem_we    = (state == SL_WRITE) && scl_rise && (bit_cnt == 3'd7);

    assign drive.scl_low  = 1'b0;   // No clock stretching.
    assign drive.data_low = data_low;

    always_ff @(posedge sda)
    begin
        if (mem_we)
            mem[addr] <= byte_in;
    end

    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            state    <= SL_IDLE;
            ack_next <= SL_IDLE;
            bus_q    <= '1;
            bit_cnt  <= 3'd0;
            addr     <= '0;
            data_low <= 1'b0;
        end
        else
        begin
            bus_q <= bus;
            if (start_det)
            begin
                state    <= SL_CTRL;
                bit_cnt  <= 3'd0;
                data_low <= 1'b0;
            end
            else if (stop_det)
            begin
                state    <= SL_IDLE;
                data_low <= 1'b0;
            end
            else
            begin
                case (state)
                    SL_CTRL, SL_ADDR, SL_WRITE:
                    begin
                        if (scl_rise)
                        begin
                            shift   <= byte_in;
                            bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 at byte end.
                            if (bit_cnt == 3'd7)
                            begin
                                state    <= SL_ACK_OUT;
                                ack_next <= SL_WRITE;
                                if (state == SL_CTRL)
                                begin
                                    if (byte_in[7:4] != `EE_DEVICE_CODE)
                                        state <= SL_IGNORE;
                                    else
                                        addr[`EE_ADDR_W-1:8] <= byte_in[3:1];
                                    ack_next <= byte_in[0] ? SL_READ : SL_ADDR;
                                end
                                else if (state == SL_ADDR)
                                    addr[7:0] <= byte_in;
                                else
                                    addr <= addr + 1'b1;
                            end
                        end
                    end
                    SL_ACK_OUT:
                    begin
                        if (scl_fall)
                        begin
                            if (!data_low)
                                data_low <= 1'b1;
                            else if (ack_next == SL_READ)
                            begin
                                state    <= SL_READ;
                                shift    <= rd_byte;
                                data_low <= !rd_byte[7];
                                bit_cnt  <= 3'd0;
                            end
                            else
                            begin
                                state    <= ack_next;
                                data_low <= 1'b0;
                            end
                        end
                    end
                    SL_READ:
                    begin
                        if (scl_fall)
                        begin
                            if (bit_cnt == 3'd7)
                            begin
                                state    <= SL_ACK_IN;
                                data_low <= 1'b0;
                                addr     <= addr + 1'b1;
                            end
                            else
                            begin
                                bit_cnt  <= bit_cnt + 3'd1;
                                shift    <= {shift[6:0], 1'b0};
                                data_low <= !shift[6];
                            end
                        end
                    end
                    SL_ACK_IN:
                    begin
                        // High ninth bit ends the read.
                        if (scl_rise && bus.data)
                            state <= SL_IDLE;
                        else if (scl_fall)
                        begin
                            state    <= SL_READ;
                            shift    <= rd_byte;
                            data_low <= !rd_byte[7];
                            bit_cnt  <= 3'd0;
                        end
                    end
                    default: state <= state;
                endcase
            end
        end
    end

    a_data_drive: assert property (@(posedge sda) disable iff (reset)
        data_low |-> (state inside {SL_ACK_OUT, SL_READ}));

endmodule

// File: src/i2c_master.sv
`include "i2c_defs.svh"

module i2c_master
    import i2c_pkg::*;
(
    input  logic       sda,
    input  logic       reset,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  logic [1:0] adr,
    input  logic [7:0] dat_w,
    input  i2c_bus_t   bus,
    output logic [7:0] dat_r,
    output logic       ack,
    output i2c_drive_t drive
);
    master_state_e state;
    master_state_e seq_next;
    cmd_reg_t      cmd_q;
    cmd_reg_t      cmd_in;
    status_reg_t   status;
    logic [7:0]    data_q;      // Transmit byte in, received byte out.
    logic [2:0]    bit_cnt;
    logic          issued;
    logic          access;
    logic          cmd_wr;
    logic          advance;
    logic          bit_req;
    bit_cmd_t      bit_cmd;
    bit_cmd_t      next_bit;
    logic          bit_done;
    logic          dout;

    // Phase that follows the current one for a given command.
    function automatic master_state_e next_phase(master_state_e cur, cmd_reg_t c);
        master_state_e nxt;
        nxt = M_DONE;
        if (cur == M_IDLE && c.start)
            nxt = M_START;
        else if ((cur == M_IDLE || cur == M_START) && (c.write || c.read))
            nxt = M_BITS;
        else if (cur != M_STOP && c.stop)
            nxt = M_STOP;
        return nxt;
    endfunction

    assign access   = cyc && stb && !ack;
    assign cmd_wr   = access && we && (adr == `REG_CMD);
    assign cmd_in   = cmd_reg_t'(dat_w[4:0]);
    assign seq_next = next_phase(state, (state == M_IDLE) ? cmd_in : cmd_q);
    assign advance  = (state == M_IDLE) ? cmd_wr :
                      ((state == M_START || state == M_ACK || state == M_STOP) && bit_done);
    assign dat_r    = (adr == `REG_STATUS) ? {6'b0, status} : data_q;

    always_comb
    begin
        next_bit.din = 1'b1;
        case (state)
            M_START: next_bit.op = BIT_START;
            M_STOP:  next_bit.op = BIT_STOP;
            M_BITS:
            begin
                next_bit.op  = cmd_q.write ? BIT_WRITE : BIT_READ;
                next_bit.din = data_q[7];
            end
            default:
            begin
                // Ninth bit goes the other way.
                next_bit.op  = cmd_q.write ? BIT_READ : BIT_WRITE;
                next_bit.din = cmd_q.nack;
            end
        endcase
    end

    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            state   <= M_IDLE;
            cmd_q   <= '0;
            status  <= '0;
            bit_cnt <= 3'd0;
            issued  <= 1'b0;
            bit_req <= 1'b0;
            ack     <= 1'b0;
        end
        else
        begin
            bit_req <= 1'b0;
            ack     <= 1'b0;
            if (state != M_IDLE && state != M_DONE && !issued)
            begin
                bit_req <= 1'b1;
                bit_cmd <= next_bit;
                issued  <= 1'b1;
            end
            case (state)
                M_IDLE:
                begin
                    if (cmd_wr)
                    begin
                        cmd_q       <= cmd_in;
                        status.busy <= 1'b1;
                    end
                    else if (access)
                    begin
                        ack <= 1'b1;
                        if (we && adr == `REG_DATA)
                            data_q <= dat_w;
                    end
                end
                M_BITS:
                begin
                    if (bit_done)
                    begin
                        issued  <= 1'b0;
                        data_q  <= {data_q[6:0], dout};  // MSB first.
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= M_ACK;
                    end
                end
                M_ACK:
                begin
                    if (bit_done && cmd_q.write)
                        status.rx_nack <= dout;
                end
                M_DONE: state <= M_IDLE;
                default: state <= state;
            endcase
            if (advance)
            begin
                issued <= 1'b0;
                state  <= seq_next;
                if (seq_next == M_DONE)
                begin
                    ack         <= 1'b1;
                    status.busy <= 1'b0;
                end
            end
        end
    end

    i2c_bit_ctrl i_bit_ctrl (
        .sda      (sda),
        .reset    (reset),
        .bit_req  (bit_req),
        .bit_cmd  (bit_cmd),
        .bus      (bus),
        .bit_done (bit_done),
        .dout     (dout),
        .drive    (drive)
    );

    a_ack_in_cycle: assert property (@(posedge sda) disable iff (reset)
        ack |-> (cyc && stb));

endmodule

// File: src/i2c_bit_ctrl.sv
`include "i2c_defs.svh"

module i2c_bit_ctrl
    import i2c_pkg::*;
(
    input  logic       sda,
    input  logic       reset,
    input  logic       bit_req,
    input  bit_cmd_t   bit_cmd,
    input  i2c_bus_t   bus,
    output logic       bit_done,
    output logic       dout,
    output i2c_drive_t drive
);
    localparam int CNT_W = $clog2(`I2C_CLK_DIV + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`I2C_CLK_DIV - 1);

    bit_cmd_t       cmd_q;
    logic           busy;
    logic           in_xfer;    // Between a start and a stop.
    logic [1:0]     phase;
    logic [CNT_W-1:0] cnt;

    // Line pattern applied at the start of each quarter.
    function automatic i2c_drive_t phase_drive(bit_cmd_t cmd, logic [1:0] ph, i2c_drive_t cur);
        i2c_drive_t nd;
        nd = cur;
        case (cmd.op)
            BIT_START:
            begin
                case (ph)
                    2'd0: nd.data_low = 1'b0;
                    2'd1: nd.scl_low = 1'b0;
                    2'd2: nd.data_low = 1'b1;  // Data falls with scl high.
                    default: nd.scl_low = 1'b1;
                endcase
            end
            BIT_STOP:
            begin
                case (ph)
                    2'd0: nd.data_low = 1'b1;
                    2'd1: nd.scl_low = 1'b0;
                    2'd2: nd.data_low = 1'b0;  // Data rises with scl high.
                    default: nd = cur;
                endcase
            end
            default:
            begin
                case (ph)
                    2'd0:
                    begin
                        nd.scl_low  = 1'b1;
                        nd.data_low = (cmd.op == BIT_WRITE) ? !cmd.din : 1'b0;
                    end
                    2'd1: nd.scl_low = 1'b0;
                    2'd2: nd = cur;
                    default: nd.scl_low = 1'b1;
                endcase
            end
        endcase
        return nd;
    endfunction

    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            in_xfer  <= 1'b0;
            phase    <= 2'd0;
            cnt      <= '0;
            bit_done <= 1'b0;
            drive    <= '0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (!busy)
            begin
                if (bit_req)
                begin
                    busy  <= 1'b1;
                    cmd_q <= bit_cmd;
                    phase <= 2'd0;
                    cnt   <= '0;
                    drive <= phase_drive(bit_cmd, 2'd0, drive);
                end
            end
            else if (cnt == CNT_LAST)
            begin
                cnt   <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd2)
                    dout <= bus.data;       // Sample while scl is high.
                if (phase == 2'd3)
                begin
                    busy     <= 1'b0;
                    bit_done <= 1'b1;
                    if (cmd_q.op == BIT_START)
                        in_xfer <= 1'b1;
                    else if (cmd_q.op == BIT_STOP)
                        in_xfer <= 1'b0;
                end
                else
                    drive <= phase_drive(cmd_q, phase + 2'd1, drive);
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    // Bus clock is released whenever no transfer is open.
    a_scl_idle: assert property (@(posedge sda) disable iff (reset)
        (!busy && !in_xfer) |-> !drive.scl_low);

endmodule

// File: src/i2c_pkg.sv
package i2c_pkg;

    // Resolved line levels.
    typedef struct packed {
        logic scl;
        logic data;
    } i2c_bus_t;

    // Open-drain pull-down request of one agent.
    typedef struct packed {
        logic scl_low;
        logic data_low;
    } i2c_drive_t;

    typedef enum logic [1:0] {
        BIT_START,
        BIT_STOP,
        BIT_WRITE,
        BIT_READ
    } bit_op_e;

    typedef struct packed {
        bit_op_e op;
        logic    din;
    } bit_cmd_t;

    // CMD register layout with start in bit 4.
    typedef struct packed {
        logic start;
        logic stop;
        logic write;
        logic read;
        logic nack;
    } cmd_reg_t;

    typedef struct packed {
        logic busy;
        logic rx_nack;
    } status_reg_t;

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_CTRL,
        SL_ADDR,
        SL_WRITE,
        SL_READ,
        SL_ACK_OUT,
        SL_ACK_IN,
        SL_IGNORE
    } slave_state_e;

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_BITS,
        M_ACK,
        M_STOP,
        M_DONE
    } master_state_e;

endpackage

// File: src/i2c_defs.svh
`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// System clocks per quarter of an I2C bit period.
`define I2C_CLK_DIV 4

// Wishbone register map.
`define REG_DATA   2'd0
`define REG_CMD    2'd1
`define REG_STATUS 2'd2

// EEPROM geometry.
`define EE_ADDR_W   11
`define EE_MEM_SIZE 2048

// Fixed upper nibble of the control byte.
`define EE_DEVICE_CODE 4'b1010

`endif
